//--- rvDecodePkg.sv
package rvDecodePkg;

	// One instruction word, viewed per RV32 format
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;     // Also funct12 and CSR address
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
		struct packed {
			logic [6:0] immHi;    // imm[11:5]
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] immLo;    // imm[4:0]
			logic [6:0] opcode;
		} s;
		struct packed {
			logic       sign;     // imm[12]
			logic [5:0] immHi;    // imm[10:5]
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] immLo;    // imm[4:1]
			logic       imm11;
			logic [6:0] opcode;
		} b;
		struct packed {
			logic [19:0] imm;     // imm[31:12]
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u;
		struct packed {
			logic       sign;     // imm[20]
			logic [9:0] immLo;    // imm[10:1]
			logic       imm11;
			logic [7:0] immHi;    // imm[19:12]
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} instrWord;

	// Major opcodes
	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opAuipc  = 7'b0010111;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opJalr   = 7'b1100111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opOpImm  = 7'b0010011;
	localparam logic [6:0] opOp     = 7'b0110011;
	localparam logic [6:0] opSystem = 7'b1110011;

	localparam logic [6:0] funct7Base   = 7'b0000000;
	localparam logic [6:0] funct7Alt    = 7'b0100000;  // sub, sra, srai
	localparam logic [6:0] funct7MulDiv = 7'b0000001;

	// Functional unit select
	localparam logic [2:0] fnAlu    = 3'd0;
	localparam logic [2:0] fnBranch = 3'd1;
	localparam logic [2:0] fnMem    = 3'd2;
	localparam logic [2:0] fnMulDiv = 3'd3;
	localparam logic [2:0] fnCsr    = 3'd4;

	localparam logic [3:0] aluAdd  = 4'd0;
	localparam logic [3:0] aluSub  = 4'd1;
	localparam logic [3:0] aluSll  = 4'd2;
	localparam logic [3:0] aluSlt  = 4'd3;
	localparam logic [3:0] aluSltu = 4'd4;
	localparam logic [3:0] aluXor  = 4'd5;
	localparam logic [3:0] aluOr   = 4'd6;
	localparam logic [3:0] aluAnd  = 4'd7;
	localparam logic [3:0] aluSrl  = 4'd8;
	localparam logic [3:0] aluSra  = 4'd9;

	localparam logic [1:0] pcPlus4   = 2'd0;
	localparam logic [1:0] pcBranch  = 2'd1;
	localparam logic [1:0] pcJump    = 2'd2;
	localparam logic [1:0] pcJumpReg = 2'd3;

	localparam logic [1:0] bSelReg = 2'd0;
	localparam logic [1:0] bSelImm = 2'd1;
	localparam logic [1:0] bSelPc4 = 2'd2;  // Link value operand

	// memOp = {store, unsigned, size}, size 01 byte, 10 half, 11 word
	localparam logic [3:0] memNone = 4'b0000;
	localparam logic [3:0] memLb   = 4'b0001;
	localparam logic [3:0] memLh   = 4'b0010;
	localparam logic [3:0] memLw   = 4'b0011;
	localparam logic [3:0] memLbu  = 4'b0101;
	localparam logic [3:0] memLhu  = 4'b0110;
	localparam logic [3:0] memSb   = 4'b1001;
	localparam logic [3:0] memSh   = 4'b1010;
	localparam logic [3:0] memSw   = 4'b1011;

	localparam logic [11:0] funct12Ecall = 12'h000;
	localparam logic [11:0] funct12Uret  = 12'h002;
	localparam logic [11:0] funct12Sret  = 12'h102;
	localparam logic [11:0] funct12Mret  = 12'h302;

	localparam logic [31:0] resetVector = 32'h0000_0000;
	localparam logic [31:0] nopWord     = 32'h0000_0013;  // addi x0, x0, 0

endpackage

//--- fetchStage.sv
`timescale 1ns/1ps

module fetchStage
	import rvDecodePkg::*;
(
	input  logic        clk,
	input  logic        nrst,
	input  logic        stall,        // Hold PC and pair
	input  logic        redirect,     // New fetch target, wins over stall
	input  logic [31:0] redirectPc,
	input  logic [31:0] instrData,    // Memory word for address sampled at last edge
	output logic [31:0] instrAddr,    // To instruction memory
	output logic [31:0] pc2,          // PC of the returning word
	output logic [31:0] instr2,
	output logic        misaligned2
);

	logic [31:0] pc;          // Next fetch PC
	logic [31:0] pcNext;
	logic        bubble2;     // Pair is on the wrong path
	logic        addrMisaligned;

	// Stalled memory re-reads the held pair so instrData keeps matching pc2
	assign instrAddr = stall ? pc2 : pc;
	assign addrMisaligned = |instrAddr[1:0];

	always_comb
	begin
		if (redirect)
			pcNext = redirectPc;    // Redirect first
		else if (stall)
			pcNext = pc;
		else
			pcNext = pc + 32'd4;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			pc          <= resetVector;
			pc2         <= resetVector;
			bubble2     <= 1'b1;    // Memory output not yet tied to a fetch
			misaligned2 <= 1'b0;
		end
		else
		begin
			pc <= pcNext;
			if (redirect)
			begin
				// Word sampled at this edge is wrong path
				pc2         <= instrAddr;
				bubble2     <= 1'b1;
				misaligned2 <= 1'b0;
			end
			else if (!stall)
			begin
				pc2         <= instrAddr;
				bubble2     <= 1'b0;
				misaligned2 <= addrMisaligned;  // Set for a bad target's pair
			end
			// Stall holds the pair as it is
		end
	end

	// Bubbles and misaligned pairs enter decode as a NOP
	assign instr2 = (bubble2 || misaligned2) ? nopWord : instrData;

endmodule

//--- instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder
	import rvDecodePkg::*;
(
	input  instrWord    instr,
	input  logic        exceptionPending,  // Trap in flight downstream
	output logic [1:0]  pcSelect,
	output logic        writeEn,           // Regfile write
	output logic [1:0]  bSel,
	output logic [3:0]  aluFn,
	output logic [2:0]  fn,                // Unit select
	output logic        bneq,              // Inverted branch sense
	output logic        btype,             // Relational compare, not equality
	output logic [2:0]  mulDivOp,
	output logic        jmp,
	output logic        jmpReg,
	output logic [3:0]  memOp,
	output logic        lui,
	output logic        auipc,
	output logic        ecall,
	output logic        mret,
	output logic        sret,
	output logic        uret,
	output logic        illegalInstr,
	output logic        csrWe
);

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [11:0] funct12;
	logic        rs1Zero;
	logic        rdZero;
	logic [3:0]  aluBase;   // funct3 to ALU op, base encodings
	logic        wrRaw;
	logic        csrWrRaw;
	logic [3:0]  memOpRaw;

	assign opcode  = instr.r.opcode;
	assign funct3  = instr.r.funct3;
	assign funct7  = instr.r.funct7;
	assign funct12 = instr.i.imm;
	assign rs1Zero = (instr.r.rs1 == 5'd0);
	assign rdZero  = (instr.r.rd == 5'd0);

	always_comb
	begin
		case (funct3)
			3'b000:  aluBase = aluAdd;
			3'b001:  aluBase = aluSll;
			3'b010:  aluBase = aluSlt;
			3'b011:  aluBase = aluSltu;
			3'b100:  aluBase = aluXor;
			3'b101:  aluBase = aluSrl;
			3'b110:  aluBase = aluOr;
			default: aluBase = aluAnd;
		endcase
	end

	always_comb
	begin
		// Defaults decode as a harmless add
		pcSelect     = pcPlus4;
		wrRaw        = 1'b0;
		bSel         = bSelReg;
		aluFn        = aluAdd;
		fn           = fnAlu;
		bneq         = 1'b0;
		btype        = 1'b0;
		mulDivOp     = 3'd0;
		jmp          = 1'b0;
		jmpReg       = 1'b0;
		memOpRaw     = memNone;
		lui          = 1'b0;
		auipc        = 1'b0;
		ecall        = 1'b0;
		mret         = 1'b0;
		sret         = 1'b0;
		uret         = 1'b0;
		illegalInstr = 1'b0;
		csrWrRaw     = 1'b0;
		case (opcode)
			opLui:
			begin
				wrRaw = 1'b1;
				bSel  = bSelImm;
				lui   = 1'b1;
			end
			opAuipc:
			begin
				wrRaw = 1'b1;
				bSel  = bSelImm;
				auipc = 1'b1;
			end
			opJal:
			begin
				wrRaw    = 1'b1;
				bSel     = bSelPc4;    // rd gets pc + 4
				fn       = fnBranch;
				jmp      = 1'b1;
				pcSelect = pcJump;
			end
			opJalr:
			begin
				if (funct3 != 3'b000)
					illegalInstr = 1'b1;
				else
				begin
					wrRaw    = 1'b1;
					bSel     = bSelPc4;
					fn       = fnBranch;
					jmpReg   = 1'b1;
					pcSelect = pcJumpReg;
				end
			end
			opBranch:
			begin
				if (funct3[2:1] == 2'b01)
					illegalInstr = 1'b1;   // No 010, 011 branches
				else
				begin
					fn       = fnBranch;
					pcSelect = pcBranch;
					btype    = funct3[2];  // blt, bge, bltu, bgeu
					bneq     = funct3[0];  // bne, bge, bgeu
					if (!funct3[2])
						aluFn = aluSub;
					else
						aluFn = funct3[1] ? aluSltu : aluSlt;
				end
			end
			opLoad:
			begin
				if (funct3 == 3'b011 || funct3[2:1] == 2'b11)
					illegalInstr = 1'b1;
				else
				begin
					wrRaw    = 1'b1;
					fn       = fnMem;
					bSel     = bSelImm;         // Address = rs1 + imm
					memOpRaw = {1'b0, funct3[2], funct3[1:0] + 2'd1};
				end
			end
			opStore:
			begin
				if (funct3[2] || funct3[1:0] == 2'b11)
					illegalInstr = 1'b1;
				else
				begin
					fn       = fnMem;
					bSel     = bSelImm;
					memOpRaw = {2'b10, funct3[1:0] + 2'd1};
				end
			end
			opOpImm:
			begin
				// Shift immediates constrain funct7
				if ((funct3 == 3'b001 && funct7 != funct7Base) ||
					(funct3 == 3'b101 && funct7 != funct7Base && funct7 != funct7Alt))
					illegalInstr = 1'b1;
				else
				begin
					wrRaw = 1'b1;
					bSel  = bSelImm;
					aluFn = (funct3 == 3'b101 && funct7 == funct7Alt) ? aluSra : aluBase;
				end
			end
			opOp:
			begin
				wrRaw = 1'b1;
				if (funct7 == funct7Base)
					aluFn = aluBase;
				else if (funct7 == funct7Alt && funct3 == 3'b000)
					aluFn = aluSub;
				else if (funct7 == funct7Alt && funct3 == 3'b101)
					aluFn = aluSra;
				else if (funct7 == funct7MulDiv)
				begin
					fn       = fnMulDiv;
					mulDivOp = funct3;       // mul .. remu in funct3 order
				end
				else
					illegalInstr = 1'b1;
			end
			opSystem:
			begin
				if (funct3 == 3'b000)
				begin
					// Privileged ops need rs1 and rd zero
					if (!rs1Zero || !rdZero)
						illegalInstr = 1'b1;
					else
					begin
						case (funct12)
							funct12Ecall: ecall = 1'b1;
							funct12Mret:  mret = 1'b1;
							funct12Sret:  sret = 1'b1;
							funct12Uret:  uret = 1'b1;
							default:      illegalInstr = 1'b1;  // ebreak, wfi unsupported
						endcase
					end
				end
				else if (funct3 == 3'b100)
					illegalInstr = 1'b1;
				else
				begin
					wrRaw    = 1'b1;
					fn       = fnCsr;
					bSel     = funct3[2] ? bSelImm : bSelReg;  // uimm forms
					// Set/clear with x0 or zero uimm is a pure read
					csrWrRaw = !(funct3[1] && rs1Zero);
				end
			end
			default:
				illegalInstr = 1'b1;
		endcase
	end

	// Pending trap kills all architectural writes
	assign writeEn = wrRaw && !illegalInstr && !exceptionPending;
	assign csrWe   = csrWrRaw && !exceptionPending;
	assign memOp   = (illegalInstr || exceptionPending) ? memNone : memOpRaw;

endmodule

//--- decodeStage.sv
`timescale 1ns/1ps

module decodeStage
	import rvDecodePkg::*;
(
	input  logic        clk,
	input  logic        nrst,
	input  logic        stall,
	input  logic        exceptionPending,
	input  logic [31:0] pc2,
	input  logic [31:0] instr2,
	input  logic        misaligned2,
	output logic [4:0]  rs1,
	output logic [4:0]  rs2,
	output logic [4:0]  rd3,
	output logic [4:0]  shamt,
	output logic [31:0] iImm3,
	output logic [31:0] bImm3,
	output logic [31:0] jImm3,
	output logic [31:0] uImm3,
	output logic [31:0] sImm3,
	output logic [31:0] pc3,
	output logic [6:0]  opcode3,
	output logic [2:0]  funct3_3,
	output logic [11:0] csrAddr3,
	output logic [31:0] csrImm3,
	output logic        misaligned3,
	output logic [1:0]  pcSelect3,
	output logic        writeEn3,
	output logic [1:0]  bSel3,
	output logic [3:0]  aluFn3,
	output logic [2:0]  fn3,
	output logic        bneq3,
	output logic        btype3,
	output logic [2:0]  mulDivOp3,
	output logic        jmp3,
	output logic        jmpReg3,
	output logic [3:0]  memOp3,
	output logic        lui3,
	output logic        auipc3,
	output logic        ecall3,
	output logic        mret3,
	output logic        sret3,
	output logic        uret3,
	output logic        illegalInstr3,
	output logic        csrWe3
);

	instrWord    instrReg3;   // Word under decode
	logic [31:0] pcReg3;
	logic        misReg3;     // Fetch-side exception

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			instrReg3.raw <= nopWord;   // Decode a NOP out of reset
			pcReg3        <= 32'd0;
			misReg3       <= 1'b0;
		end
		else if (!stall)
		begin
			instrReg3.raw <= instr2;
			pcReg3        <= pc2;
			misReg3       <= misaligned2;
		end
	end

	// Register fields
	assign rs1   = instrReg3.r.rs1;
	assign rs2   = instrReg3.r.rs2;
	assign rd3   = instrReg3.r.rd;
	assign shamt = instrReg3.i.imm[4:0];

	// Immediates, all sign-extended from bit 31
	assign iImm3 = {{20{instrReg3.i.imm[11]}}, instrReg3.i.imm};
	assign sImm3 = {{20{instrReg3.s.immHi[6]}}, instrReg3.s.immHi, instrReg3.s.immLo};
	assign bImm3 = {{20{instrReg3.b.sign}}, instrReg3.b.imm11, instrReg3.b.immHi,
		instrReg3.b.immLo, 1'b0};
	assign jImm3 = {{12{instrReg3.j.sign}}, instrReg3.j.immHi, instrReg3.j.imm11,
		instrReg3.j.immLo, 1'b0};
	assign uImm3 = {instrReg3.u.imm, 12'd0};   // Low bits zero

	assign pc3         = pcReg3;
	assign misaligned3 = misReg3;
	assign opcode3     = instrReg3.r.opcode;
	assign funct3_3    = instrReg3.i.funct3;   // CSR op select

	// CSR address and zero-extended uimm
	assign csrAddr3 = instrReg3.i.imm;
	assign csrImm3  = {27'd0, instrReg3.i.rs1};

	instrDecoder instrDecoder_inst (
		.instr            (instrReg3),
		.exceptionPending (exceptionPending),
		.pcSelect         (pcSelect3),
		.writeEn          (writeEn3),
		.bSel             (bSel3),
		.aluFn            (aluFn3),
		.fn               (fn3),
		.bneq             (bneq3),
		.btype            (btype3),
		.mulDivOp         (mulDivOp3),
		.jmp              (jmp3),
		.jmpReg           (jmpReg3),
		.memOp            (memOp3),
		.lui              (lui3),
		.auipc            (auipc3),
		.ecall            (ecall3),
		.mret             (mret3),
		.sret             (sret3),
		.uret             (uret3),
		.illegalInstr     (illegalInstr3),
		.csrWe            (csrWe3)
	);

endmodule

//--- frontDecodeTop.sv
`timescale 1ns/1ps

module frontDecodeTop (
	input  logic        clk,
	input  logic        nrst,
	input  logic        stall,
	input  logic        redirect,
	input  logic [31:0] redirectPc,
	input  logic        exceptionPending,
	output logic [31:0] instrAddr,      // Instruction memory address
	input  logic [31:0] instrData,      // Returned one clock later
	output logic [4:0]  rs1,
	output logic [4:0]  rs2,
	output logic [4:0]  rd3,
	output logic [4:0]  shamt,
	output logic [31:0] iImm3,
	output logic [31:0] bImm3,
	output logic [31:0] jImm3,
	output logic [31:0] uImm3,
	output logic [31:0] sImm3,
	output logic [31:0] pc3,
	output logic [6:0]  opcode3,
	output logic [2:0]  funct3_3,
	output logic [11:0] csrAddr3,
	output logic [31:0] csrImm3,
	output logic        misaligned3,
	output logic [1:0]  pcSelect3,
	output logic        writeEn3,
	output logic [1:0]  bSel3,
	output logic [3:0]  aluFn3,
	output logic [2:0]  fn3,
	output logic        bneq3,
	output logic        btype3,
	output logic [2:0]  mulDivOp3,
	output logic        jmp3,
	output logic        jmpReg3,
	output logic [3:0]  memOp3,
	output logic        lui3,
	output logic        auipc3,
	output logic        ecall3,
	output logic        mret3,
	output logic        sret3,
	output logic        uret3,
	output logic        illegalInstr3,
	output logic        csrWe3
);

	// Fetch pair into decode
	logic [31:0] pc2;
	logic [31:0] instr2;
	logic        misaligned2;

	fetchStage fetchStage_inst (
		.clk         (clk),
		.nrst        (nrst),
		.stall       (stall),
		.redirect    (redirect),
		.redirectPc  (redirectPc),
		.instrData   (instrData),
		.instrAddr   (instrAddr),
		.pc2         (pc2),
		.instr2      (instr2),
		.misaligned2 (misaligned2)
	);

	decodeStage decodeStage_inst (
		.clk              (clk),
		.nrst             (nrst),
		.stall            (stall),
		.exceptionPending (exceptionPending),
		.pc2              (pc2),
		.instr2           (instr2),
		.misaligned2      (misaligned2),
		.rs1              (rs1),
		.rs2              (rs2),
		.rd3              (rd3),
		.shamt            (shamt),
		.iImm3            (iImm3),
		.bImm3            (bImm3),
		.jImm3            (jImm3),
		.uImm3            (uImm3),
		.sImm3            (sImm3),
		.pc3              (pc3),
		.opcode3          (opcode3),
		.funct3_3         (funct3_3),
		.csrAddr3         (csrAddr3),
		.csrImm3          (csrImm3),
		.misaligned3      (misaligned3),
		.pcSelect3        (pcSelect3),
		.writeEn3         (writeEn3),
		.bSel3            (bSel3),
		.aluFn3           (aluFn3),
		.fn3              (fn3),
		.bneq3            (bneq3),
		.btype3           (btype3),
		.mulDivOp3        (mulDivOp3),
		.jmp3             (jmp3),
		.jmpReg3          (jmpReg3),
		.memOp3           (memOp3),
		.lui3             (lui3),
		.auipc3           (auipc3),
		.ecall3           (ecall3),
		.mret3            (mret3),
		.sret3            (sret3),
		.uret3            (uret3),
		.illegalInstr3    (illegalInstr3),
		.csrWe3           (csrWe3)
	);

endmodule

//--- frontDecode_chk.sv
`timescale 1ns/1ps

module frontDecodeChk (
	input logic        clk,
	input logic        nrst,
	input logic        stall,
	input logic        exceptionPending,
	input logic [31:0] pc3,
	input logic [6:0]  opcode3,
	input logic        writeEn3,
	input logic        csrWe3,
	input logic        illegalInstr3
);

	int failCount = 0;   // Polled by the testbench

	// Decode register frozen over a stalled edge
	holdOnStall: assert property (@(posedge clk) disable iff (!nrst)
		stall |=> ($stable(pc3) && $stable(opcode3)))
		else
		begin
			$error("decode output moved across a stalled edge");
			failCount++;
		end

	quietAfterReset: assert property (@(posedge clk)
		$rose(nrst) |-> (!csrWe3 && !illegalInstr3))
		else
		begin
			$error("CSR write or illegal flag active out of reset");
			failCount++;
		end

	noWriteOnTrap: assert property (@(posedge clk) disable iff (!nrst)
		exceptionPending |-> !writeEn3)
		else
		begin
			$error("register write while exception pending");
			failCount++;
		end

endmodule

bind frontDecodeTop frontDecodeChk frontDecodeChk_inst (
	.clk              (clk),
	.nrst             (nrst),
	.stall            (stall),
	.exceptionPending (exceptionPending),
	.pc3              (pc3),
	.opcode3          (opcode3),
	.writeEn3         (writeEn3),
	.csrWe3           (csrWe3),
	.illegalInstr3    (illegalInstr3)
);

//--- frontDecodeTb.sv
`timescale 1ns/1ps

module frontDecodeTb
	import rvDecodePkg::*;
();

	logic        clk;
	logic        nrst;
	logic        stall;
	logic        redirect;
	logic [31:0] redirectPc;
	logic        exceptionPending;
	logic [31:0] instrAddr;
	logic [31:0] instrData;
	logic [4:0]  rs1, rs2, rd3, shamt;
	logic [31:0] iImm3, bImm3, jImm3, uImm3, sImm3, pc3, csrImm3;
	logic [6:0]  opcode3;
	logic [2:0]  funct3_3, fn3, mulDivOp3;
	logic [11:0] csrAddr3;
	logic [1:0]  pcSelect3, bSel3;
	logic [3:0]  aluFn3, memOp3;
	logic        misaligned3, writeEn3, bneq3, btype3, jmp3, jmpReg3, lui3, auipc3;
	logic        ecall3, mret3, sret3, uret3, illegalInstr3, csrWe3;

	logic [31:0] imem [0:255];  // Instruction memory model
	logic [31:0] lfsr;

	// Model of fetch pair and decode register
	logic [31:0] mPc, mPc2, mPc3, mW3;
	logic        mBub2, mMis2, mMis3;
	logic        curStall, curEp;   // Inputs on the wires right now

	frontDecodeTop frontDecodeTop_inst (.*);

	always #4 clk = ~clk;

	// Synchronous read, word for the address sampled at the edge
	always @(posedge clk)
		instrData <= #1 imem[instrAddr[9:2]];

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		int b;
		v = 32'd0;
		for (b = 0; b < n; b++)
		begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsrStep(lfsr);
		end
		return v;
	endfunction

	// Random word, mostly legal, biased by format class
	function automatic logic [31:0] genWord();
		instrWord w;
		logic [3:0] kind;
		logic [1:0] k;
		w.raw = randBits(32);
		kind = 4'(randBits(4));
		case (kind)
			4'd0: w.u.opcode = opLui;
			4'd1: w.u.opcode = opAuipc;
			4'd2: w.j.opcode = opJal;
			4'd3:
			begin
				w.i.opcode = opJalr;
				w.i.funct3 = 3'b000;
			end
			4'd4:
			begin
				w.b.opcode = opBranch;
				if (w.b.funct3[2:1] == 2'b01)
					w.b.funct3[1] = 1'b0;    // Fold onto beq/bne
			end
			4'd5:
			begin
				w.i.opcode = opLoad;
				if (w.i.funct3 == 3'b011 || w.i.funct3[2:1] == 2'b11)
					w.i.funct3 = 3'b010;
			end
			4'd6:
			begin
				w.s.opcode = opStore;
				if (w.s.funct3[2] || w.s.funct3[1:0] == 2'b11)
					w.s.funct3 = 3'b010;
			end
			4'd7, 4'd8:
			begin
				w.r.opcode = opOpImm;
				if (w.r.funct3 == 3'b001 || w.r.funct3 == 3'b101)
					w.r.funct7 = (w.r.funct7[5] && w.r.funct3[2]) ? funct7Alt : funct7Base;
			end
			4'd9, 4'd10:
			begin
				w.r.opcode = opOp;
				k = 2'(randBits(2));
				if (k == 2'd2)
					w.r.funct7 = funct7MulDiv;
				else if (k == 2'd3)
				begin
					w.r.funct7 = funct7Alt;
					w.r.funct3 = {w.r.funct3[0], 1'b0, w.r.funct3[0]};  // sub or sra
				end
				else
					w.r.funct7 = funct7Base;
			end
			4'd11, 4'd12:
			begin
				w.i.opcode = opSystem;
				if (w.i.funct3[1:0] == 2'b00)
					w.i.funct3[0] = 1'b1;    // CSR ops only
				if (randBits(1) != 0)
					w.i.rs1 = 5'd0;          // Read-only candidates
			end
			4'd13:
			begin
				w.i.opcode = opSystem;
				w.i.funct3 = 3'b000;
				w.i.rs1    = 5'd0;
				w.i.rd     = 5'd0;
				k = 2'(randBits(2));
				case (k)
					2'd0:    w.i.imm = funct12Ecall;
					2'd1:    w.i.imm = funct12Mret;
					2'd2:    w.i.imm = funct12Sret;
					default: w.i.imm = funct12Uret;
				endcase
			end
			4'd14: ;    // Raw random, usually illegal
			default:
			begin
				w.r.opcode = opOp;
				w.r.funct7 = 7'b0000010;    // Undefined funct7
			end
		endcase
		return w.raw;
	endfunction

	// Legality from the RV32IM encoding tables
	function automatic logic isIllegal(input logic [31:0] w);
		logic [2:0] f3;
		logic [6:0] f7;
		f3 = w[14:12];
		f7 = w[31:25];
		case (w[6:0])
			opLui, opAuipc, opJal: return 1'b0;
			opJalr:   return f3 != 3'd0;
			opBranch: return f3 == 3'd2 || f3 == 3'd3;
			opLoad:   return f3 == 3'd3 || f3 == 3'd6 || f3 == 3'd7;
			opStore:  return f3 > 3'd2;
			opOpImm:  return (f3 == 3'd1 && f7 != 7'h00) ||
				(f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
			opOp:     return !(f7 == 7'h00 || f7 == 7'h01 ||
				(f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
			opSystem:
			begin
				if (f3 == 3'd4)
					return 1'b1;
				if (f3 != 3'd0)
					return 1'b0;
				if (w[19:15] != 5'd0 || w[11:7] != 5'd0)
					return 1'b1;
				return !(w[31:20] == 12'h000 || w[31:20] == 12'h002 ||
					w[31:20] == 12'h102 || w[31:20] == 12'h302);
			end
			default:  return 1'b1;
		endcase
	endfunction

	function automatic logic [3:0] aluOf(input logic [2:0] f3, input logic alt);
		case (f3)
			3'd0:    return alt ? aluSub : aluAdd;
			3'd1:    return aluSll;
			3'd2:    return aluSlt;
			3'd3:    return aluSltu;
			3'd4:    return aluXor;
			3'd5:    return alt ? aluSra : aluSrl;
			3'd6:    return aluOr;
			default: return aluAnd;
		endcase
	endfunction

	// Reference controls, packed in the same order as the DUT bundle
	function automatic logic [41:0] expectCtrl(input logic [31:0] w, input logic mis,
		input logic ep);
		logic [2:0] f3, fu, md;
		logic [1:0] pcs, bs;
		logic [3:0] alu, mop;
		logic       wr, bn, bt, j, jr, lu, au, ec, mr, sr, ur, ill, cw;
		f3  = w[14:12];
		pcs = pcPlus4;
		bs  = bSelReg;
		alu = aluAdd;
		fu  = fnAlu;
		md  = 3'd0;
		mop = memNone;
		{wr, bn, bt, j, jr, lu, au, ec, mr, sr, ur, cw} = 12'd0;
		ill = isIllegal(w);
		if (!ill)
		begin
			case (w[6:0])
				opLui:   {wr, bs, lu} = {1'b1, bSelImm, 1'b1};
				opAuipc: {wr, bs, au} = {1'b1, bSelImm, 1'b1};
				opJal:   {wr, bs, fu, j, pcs} = {1'b1, bSelPc4, fnBranch, 1'b1, pcJump};
				opJalr:  {wr, bs, fu, jr, pcs} = {1'b1, bSelPc4, fnBranch, 1'b1, pcJumpReg};
				opBranch:
				begin
					fu  = fnBranch;
					pcs = pcBranch;
					bt  = f3[2];    // blt, bge, bltu, bgeu
					bn  = f3[0];    // bne, bge, bgeu
					alu = !f3[2] ? aluSub : (f3[1] ? aluSltu : aluSlt);
				end
				opLoad:
				begin
					{wr, fu, bs} = {1'b1, fnMem, bSelImm};
					case (f3)
						3'd0:    mop = memLb;
						3'd1:    mop = memLh;
						3'd2:    mop = memLw;
						3'd4:    mop = memLbu;
						default: mop = memLhu;
					endcase
				end
				opStore:
				begin
					{fu, bs} = {fnMem, bSelImm};
					mop = (f3 == 3'd0) ? memSb : ((f3 == 3'd1) ? memSh : memSw);
				end
				opOpImm:
				begin
					{wr, bs} = {1'b1, bSelImm};
					alu = aluOf(f3, f3 == 3'd5 && w[31:25] == 7'h20);
				end
				opOp:
				begin
					wr = 1'b1;
					if (w[31:25] == 7'h01)
						{fu, md} = {fnMulDiv, f3};
					else
						alu = aluOf(f3, w[31:25] == 7'h20);
				end
				default:    // SYSTEM
				begin
					if (f3 == 3'd0)
					begin
						ec = w[31:20] == 12'h000;
						ur = w[31:20] == 12'h002;
						sr = w[31:20] == 12'h102;
						mr = w[31:20] == 12'h302;
					end
					else
					begin
						{wr, fu} = {1'b1, fnCsr};
						bs = f3[2] ? bSelImm : bSelReg;
						cw = !(f3[1] && w[19:15] == 5'd0);  // csrrs/c with zero source
					end
				end
			endcase
		end
		if (ep)
		begin
			wr  = 1'b0;
			cw  = 1'b0;
			mop = memNone;
		end
		return {mis, w[6:0], f3, pcs, wr, bs, alu, fu, bn, bt, md, j, jr, mop,
			lu, au, ec, mr, sr, ur, ill, cw};
	endfunction

	// Field names and widths from the LSB of the bundle
	function automatic string ctrlName(input int k);
		case (k)
			0: return "csrWe3";
			1: return "illegalInstr3";
			2: return "uret3";
			3: return "sret3";
			4: return "mret3";
			5: return "ecall3";
			6: return "auipc3";
			7: return "lui3";
			8: return "memOp3";
			9: return "jmpReg3";
			10: return "jmp3";
			11: return "mulDivOp3";
			12: return "btype3";
			13: return "bneq3";
			14: return "fn3";
			15: return "aluFn3";
			16: return "bSel3";
			17: return "writeEn3";
			18: return "pcSelect3";
			19: return "funct3_3";
			20: return "opcode3";
			default: return "misaligned3";
		endcase
	endfunction

	function automatic int ctrlWidth(input int k);
		case (k)
			8, 15: return 4;
			11, 14, 19: return 3;
			16, 18: return 2;
			20: return 7;
			default: return 1;
		endcase
	endfunction

	task automatic abortRun();
		$display("sim failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
		begin
			$display("ERROR at %0t: %s expected %h, actual %h", $time, name, exp, act);
			abortRun();
		end
	endtask

	task automatic checkReg(input string name, input logic [4:0] exp, input logic [4:0] act);
		if (act !== exp)
		begin
			$display("ERROR at %0t: %s expected x%0d, actual x%0d", $time, name, exp, act);
			abortRun();
		end
	endtask

	task automatic checkCtrl(input logic [41:0] exp, input logic [41:0] act);
		int lsb;
		int k;
		logic [41:0] mask, e, a;
		lsb = 0;
		for (k = 0; k < 22; k++)
		begin
			mask = (42'd1 << ctrlWidth(k)) - 42'd1;
			e = (exp >> lsb) & mask;
			a = (act >> lsb) & mask;
			if (e !== a)
			begin
				$display("ERROR at %0t: %s expected %0h, actual %0h", $time, ctrlName(k), e, a);
				abortRun();
			end
			lsb = lsb + ctrlWidth(k);
		end
	endtask

	// Fetch and decode rules applied at one clock edge
	task automatic modelEdge(input logic s, input logic r, input logic [31:0] rpc);
		logic [31:0] addr;
		addr = s ? mPc2 : mPc;
		if (!s)
		begin
			mW3   = (mBub2 || mMis2) ? nopWord : imem[mPc2[9:2]];
			mPc3  = mPc2;
			mMis3 = mMis2;
		end
		if (r)
		begin
			{mPc2, mBub2, mMis2} = {addr, 1'b1, 1'b0};   // Wrong-path pair
			mPc = rpc;
		end
		else if (!s)
		begin
			{mPc2, mBub2, mMis2} = {addr, 1'b0, |addr[1:0]};
			mPc = mPc + 32'd4;
		end
	endtask

	task automatic checkOutputs();
		logic [31:0] w;
		logic [41:0] act;
		w = mW3;
		act = {misaligned3, opcode3, funct3_3, pcSelect3, writeEn3, bSel3, aluFn3, fn3,
			bneq3, btype3, mulDivOp3, jmp3, jmpReg3, memOp3, lui3, auipc3, ecall3, mret3,
			sret3, uret3, illegalInstr3, csrWe3};
		checkWord("pc3", mPc3, pc3);
		checkWord("instrAddr", curStall ? mPc2 : mPc, instrAddr);
		checkReg("rs1", w[19:15], rs1);
		checkReg("rs2", w[24:20], rs2);
		checkReg("rd3", w[11:7], rd3);
		checkReg("shamt", w[24:20], shamt);
		checkWord("iImm3", {{20{w[31]}}, w[31:20]}, iImm3);
		checkWord("sImm3", {{20{w[31]}}, w[31:25], w[11:7]}, sImm3);
		checkWord("bImm3", {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0}, bImm3);
		checkWord("jImm3", {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0}, jImm3);
		checkWord("uImm3", {w[31:12], 12'd0}, uImm3);
		checkWord("csrImm3", {27'd0, w[19:15]}, csrImm3);
		checkWord("csrAddr3", {20'd0, w[31:20]}, {20'd0, csrAddr3});
		checkCtrl(expectCtrl(w, mMis3, curEp), act);
		if (frontDecodeTop_inst.frontDecodeChk_inst.failCount != 0)
		begin
			$display("A bound assertion on the top level failed at %0t", $time);
			abortRun();
		end
	endtask

	// Drive one cycle of inputs, then check after the edge
	task automatic stepCycle(input logic s, input logic r, input logic [31:0] rpc,
		input logic ep);
		stall            = s;
		redirect         = r;
		redirectPc       = rpc;
		exceptionPending = ep;
		curStall = s;
		curEp    = ep;
		@(posedge clk);
		#1;
		modelEdge(s, r, rpc);
		checkOutputs();
	endtask

	task automatic waitPc3(input logic [31:0] target, input int limit);
		int n;
		n = 0;
		while (pc3 !== target)
		begin
			if (n == limit)
			begin
				$display("Timed out waiting for pc3 to reach %h", target);
				abortRun();
			end
			stepCycle(1'b0, 1'b0, 32'd0, 1'b0);
			n++;
		end
	endtask

	task automatic runRandom(input int n, input logic useStall, input logic useRedir,
		input logic useEp);
		int i;
		logic s, r, ep;
		logic [31:0] rpc;
		for (i = 0; i < n; i++)
		begin
			s   = useStall && (randBits(2) == 0);
			r   = useRedir && (randBits(4) == 0);
			rpc = randBits(10);
			if (randBits(2) != 0)
				rpc[1:0] = 2'b00;     // Mostly aligned targets
			ep  = useEp && (randBits(3) == 0);
			stepCycle(s, r, rpc, ep);
		end
	endtask

	initial
	begin
		int i;
		clk = 1'b0;
		nrst = 1'b0;
		stall = 1'b0;
		redirect = 1'b0;
		redirectPc = 32'd0;
		exceptionPending = 1'b0;
		instrData = 32'd0;
		{curStall, curEp} = 2'b00;
		lfsr = 32'd28;
		for (i = 0; i < 256; i++)
			imem[i] = genWord();
		{mPc, mPc2, mPc3, mW3} = {resetVector, resetVector, 32'd0, nopWord};
		{mBub2, mMis2, mMis3} = 3'b100;
		repeat (16) @(posedge clk);
		#1 nrst = 1'b1;
		checkOutputs();                 // NOP state out of reset

		waitPc3(32'h80, 64);            // Straight-line flow
		runRandom(300, 1'b1, 1'b0, 1'b0);   // Stall bursts only
		stepCycle(1'b0, 1'b1, 32'h200, 1'b0);
		waitPc3(32'h200, 8);
		stepCycle(1'b0, 1'b1, 32'h102, 1'b0);   // Misaligned target
		waitPc3(32'h102, 8);
		stepCycle(1'b0, 1'b1, 32'h40, 1'b0);
		waitPc3(32'h40, 8);
		runRandom(300, 1'b0, 1'b1, 1'b0);
		runRandom(300, 1'b0, 1'b0, 1'b1);   // Trap masking
		runRandom(2000, 1'b1, 1'b1, 1'b1);

		if (frontDecodeTop_inst.frontDecodeChk_inst.failCount == 0)
		begin
			$display("sim passed");
			$finish;
		end
		else
		begin
			$display("Bound assertions failed during the run");
			abortRun();
		end
	end

endmodule

//--- compile.f
rvDecodePkg.sv
fetchStage.sv
instrDecoder.sv
decodeStage.sv
frontDecodeTop.sv
frontDecode_chk.sv
frontDecodeTb.sv

//--- Bender.yml
package:
  name: front_decode

sources:
  - rvDecodePkg.sv
  - fetchStage.sv
  - instrDecoder.sv
  - decodeStage.sv
  - frontDecodeTop.sv
  - target: test
    files:
      - frontDecode_chk.sv
      - frontDecodeTb.sv
